//--- dv/ss_isa_model.svh
`ifndef SS_ISA_MODEL_SVH
`define SS_ISA_MODEL_SVH

// ==========================================================================
// Reference model of the kept RV32I integer subset
// ==========================================================================

// Architectural registers, x0 never written
logic [31:0] model_regs [32];

// Expected retire records in program order
logic [4:0]  exp_rd   [$];
logic [31:0] exp_data [$];

// Integer result by funct3, alt picks SUB or SRA
function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic model_reset();
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
    exp_rd.delete();
    exp_data.delete();
endtask

// One instruction in program order
task automatic model_step(input logic [31:0] instr);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] res;
    logic        writes;
    rd     = instr[11:7];
    f3     = instr[14:12];
    a      = model_regs[instr[19:15]];
    writes = 1'b1;
    case (instr[6:0])
        // Register-register
        7'h33:   res = model_alu(f3, instr[30], a, model_regs[instr[24:20]]);
        // Register-immediate, bit 30 only means SRAI
        7'h13:   res = model_alu(f3, instr[30] && f3 == 3'b101, a,
                                 {{20{instr[31]}}, instr[31:20]});
        7'h37:   res = {instr[31:12], 12'h000};
        // Everything else writes nothing
        default: begin
            res    = '0;
            writes = 1'b0;
        end
    endcase
    if (writes && rd != 5'd0) begin
        model_regs[rd] = res;
        exp_rd.push_back(rd);
        exp_data.push_back(res);
    end
endtask

`endif

//--- dv/ss_core_tb.sv
`include "ss_core_cfg.svh"

module ss_core_tb
    import ss_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_TESTS  = 4;
    localparam int          PROG_WORDS = 65;
    localparam int          IMEM_WORDS = 64;
    localparam int          IDLE_TAIL  = 8;
    // addi x0,x0,0
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

    // ======================================================================
    // Test table, slices of one instruction array
    // ======================================================================

    string test_name  [NUM_TESTS] = '{"alu_mix", "dep_split", "same_rd_x0", "long_chain"};
    int    test_start [NUM_TESTS] = '{0, 21, 28, 35};
    int    test_len   [NUM_TESTS] = '{21, 7, 7, 30};
    bit    test_stall [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] imem [IMEM_WORDS];

    logic                               clk;
    logic                               reset;
    word_t   [`SS_ISSUE_WIDTH-1:0]      inst_addr;
    word_t   [`SS_ISSUE_WIDTH-1:0]      instr;
    retire_t [`SS_ISSUE_WIDTH-1:0]      retire;
    perf_t                              perf;
    occ_t                               occupancy;

    int error_count;
    int pass_count;
    int fail_count;

    `include "ss_isa_model.svh"

    ss_core_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .inst_addr_o (inst_addr),
        .instr_i     (instr),
        .retire_o    (retire),
        .perf_o      (perf),
        .occupancy_o (occupancy)
    );

    always #5 clk = ~clk;

    // Instruction memory, same-cycle answer, NOP past the end
    always_comb begin
        for (int i = 0; i < `SS_ISSUE_WIDTH; i++) begin
            if (inst_addr[i][31:2] < IMEM_WORDS) begin
                instr[i] = imem[inst_addr[i][7:2]];
            end else begin
                instr[i] = NOP_WORD;
            end
        end
    end

    // ======================================================================
    // Encoders and helpers
    // ======================================================================

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    // Per test 4 cycles an instruction plus fixed overhead
    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += 4 * test_len[t] + 40;
        end
        return total;
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch test %s %s expected %h actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic build_programs();
        // Independent mix, every kept operation
        prog[0]  = enc_lui(20'h80001, 5'd1);
        prog[1]  = enc_i(12'hffb, 5'd0, 3'b000, 5'd2);
        prog[2]  = enc_i(12'd7, 5'd0, 3'b000, 5'd3);
        prog[3]  = enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd4);
        prog[4]  = enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd5);
        prog[5]  = enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd6);
        prog[6]  = enc_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd7);
        prog[7]  = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8);
        prog[8]  = enc_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd9);
        prog[9]  = enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd10);
        prog[10] = enc_r(7'h00, 5'd3, 5'd3, 3'b001, 5'd11);
        prog[11] = enc_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd12);
        prog[12] = enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd13);
        prog[13] = enc_i(12'hffc, 5'd2, 3'b010, 5'd14);
        prog[14] = enc_i(12'd3, 5'd2, 3'b011, 5'd15);
        prog[15] = enc_i(12'hfff, 5'd3, 3'b100, 5'd16);
        prog[16] = enc_i(12'h700, 5'd3, 3'b110, 5'd17);
        prog[17] = enc_i(12'h0f0, 5'd2, 3'b111, 5'd18);
        prog[18] = enc_i(12'd28, 5'd3, 3'b001, 5'd19);
        prog[19] = enc_i(12'd4, 5'd1, 3'b101, 5'd20);
        prog[20] = enc_i({7'h20, 5'd4}, 5'd1, 3'b101, 5'd21);
        // Slots 1 and 2 read slot 0
        prog[21] = enc_i(12'd100, 5'd0, 3'b000, 5'd1);
        prog[22] = enc_i(12'd5, 5'd1, 3'b000, 5'd2);
        prog[23] = enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd3);
        prog[24] = enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
        prog[25] = enc_lui(20'h12345, 5'd5);
        prog[26] = enc_i(12'h678, 5'd5, 3'b000, 5'd5);
        prog[27] = enc_i(12'd4, 5'd5, 3'b001, 5'd6);
        // Same rd in one group, then writes and reads of x0
        prog[28] = enc_i(12'd11, 5'd0, 3'b000, 5'd1);
        prog[29] = enc_i(12'd22, 5'd0, 3'b000, 5'd1);
        prog[30] = enc_i(12'd99, 5'd0, 3'b000, 5'd0);
        prog[31] = enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd2);
        prog[32] = enc_lui(20'hfffff, 5'd0);
        prog[33] = enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd3);
        prog[34] = enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0);
        // Serial chain on x1, one issue per cycle
        prog[35] = enc_i(12'd1, 5'd0, 3'b000, 5'd1);
        for (int k = 1; k < 30; k++) begin
            prog[35 + k] = enc_i(12'(k), 5'd1, 3'b000, 5'd1);
        end
    endtask

    task automatic load_program(input int start, input int len);
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem[a] = NOP_WORD;
        end
        for (int k = 0; k < len; k++) begin
            imem[k] = prog[start + k];
        end
    endtask

    // ======================================================================
    // Per-cycle checks at the falling edge
    // ======================================================================

    task automatic sample_cycle(input string name, input int edges, inout int records);
        // Lanes in program order
        for (int l = 0; l < `SS_ISSUE_WIDTH; l++) begin
            if (retire[l].valid === 1'b1) begin
                if (exp_rd.size() == 0) begin
                    $display("test %s: lane %0d retired x%0d although no result was due",
                             name, l, retire[l].rd);
                    error_count++;
                end else begin
                    compare_value(name, "retire rd", 32'(exp_rd[0]), 32'(retire[l].rd));
                    compare_value(name, "retire data", exp_data[0], retire[l].data);
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                    records++;
                end
            end
        end
        // Counter rules
        compare_value(name, "fetched-executed", perf.fetched - perf.executed, 32'(occupancy));
        compare_value(name, "fetched mod 3", 32'd0, perf.fetched % 3);
        compare_value(name, "occupancy in range", 32'd1, 32'(occupancy <= `SS_BUF_DEPTH));
        compare_value(name, "cycles", 32'(edges), perf.cycles);
    endtask

    task automatic run_test(input int t);
        int   edges;
        int   idle;
        int   records;
        int   errs_before;
        logic drained;
        edges       = 0;
        idle        = 0;
        records     = 0;
        errs_before = error_count;
        @(negedge clk);
        reset = 1'b0;
        load_program(test_start[t], test_len[t]);
        model_reset();
        for (int k = 0; k < test_len[t]; k++) begin
            model_step(prog[test_start[t] + k]);
        end
        repeat (2) @(negedge clk);
        reset = 1'b1;
        // Until every record is in, then a quiet tail
        while (idle < IDLE_TAIL) begin
            @(negedge clk);
            edges++;
            drained = (exp_rd.size() == 0);
            sample_cycle(test_name[t], edges, records);
            if (drained) begin
                idle++;
            end
        end
        if (test_stall[t]) begin
            compare_value(test_name[t], "buffer_stalls nonzero", 32'd1,
                          32'(perf.buffer_stalls != 0));
        end
        if (error_count == errs_before) begin
            pass_count++;
            $display("test %-11s passed  records %0d  cycles %0d", test_name[t], records, edges);
        end else begin
            fail_count++;
            $display("test %-11s failed  errors %0d  records %0d  cycles %0d",
                     test_name[t], error_count - errs_before, records, edges);
        end
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        clk         = 1'b0;
        reset       = 1'b0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        build_programs();
        load_program(0, 0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- hdl/execute_stage.sv
`include "ss_core_cfg.svh"

module execute_stage
    import ss_core_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  uop_t    [`SS_ISSUE_WIDTH-1:0]     uops_i,
    input  word_t   [`SS_ISSUE_WIDTH-1:0]     rs1_data_i,
    input  word_t   [`SS_ISSUE_WIDTH-1:0]     rs2_data_i,
    output retire_t [`SS_ISSUE_WIDTH-1:0]     wr_o,
    output retire_t [`SS_ISSUE_WIDTH-1:0]     retire_o,
    output logic    [1:0]                     executed_count_o
);

    // Single ALU lane
    function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return word_t'($signed(a) >>> sh);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    retire_t [`SS_ISSUE_WIDTH-1:0] retire_q;

    always_comb begin
        logic [1:0] cnt;
        word_t      op_b;
        cnt = '0;
        for (int i = 0; i < `SS_ISSUE_WIDTH; i++) begin
            // Immediate or rs2 as second operand
            op_b          = uops_i[i].use_imm ? uops_i[i].imm : rs2_data_i[i];
            wr_o[i].valid = uops_i[i].valid && uops_i[i].writes_rd;
            wr_o[i].rd    = uops_i[i].rd;
            wr_o[i].data  = alu(uops_i[i].alu_op, rs1_data_i[i], op_b);
            // No-ops count as executed too
            cnt           = cnt + 2'(uops_i[i].valid);
        end
        executed_count_o = cnt;
    end

    // Retire port, one cycle after the register write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            retire_q <= '0;
        end else begin
            retire_q <= wr_o;
        end
    end

    assign retire_o = retire_q;

endmodule

//--- hdl/fetch_buffer.sv
`include "ss_core_cfg.svh"

module fetch_buffer
    import ss_core_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    // Three consecutive instruction memory words
    output word_t        [`SS_ISSUE_WIDTH-1:0]    inst_addr_o,
    input  word_t        [`SS_ISSUE_WIDTH-1:0]    instr_i,
    // Pop request from issue
    input  logic         [1:0]                    issue_count_i,
    output fetch_entry_t [`SS_ISSUE_WIDTH-1:0]    head_o,
    output occ_t                                  occupancy_o,
    // Status toward the counters
    output logic                                  fetch_strobe_o,
    output logic                                  stall_o
);

    localparam int PTR_W = $clog2(`SS_BUF_DEPTH);
    localparam int FW    = `SS_ISSUE_WIDTH;

    // ======================================================================
    // State
    // ======================================================================

    word_t             pc_q;
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    occ_t              occ_q;

    // Entry storage
    fetch_entry_t      buf_mem [`SS_BUF_DEPTH];

    logic              fetch_en;

    // Room for a whole group before this cycle's pop
    assign fetch_en = (occ_q <= occ_t'(`SS_BUF_DEPTH - FW));

    assign fetch_strobe_o = fetch_en;
    // Fetch held for lack of space
    assign stall_o        = !fetch_en;
    assign occupancy_o    = occ_q;

    // Word addresses PC, PC+4, PC+8
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            inst_addr_o[i] = pc_q + word_t'(4 * i);
        end
    end

    // Oldest three entries at the read pointer
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            head_o[i] = buf_mem[rd_ptr_q + PTR_W'(i)];
        end
    end

    // ======================================================================
    // Pointer, occupancy and PC update
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q     <= word_t'(`SS_RESET_PC);
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            // Pop whatever issue took this cycle
            rd_ptr_q <= rd_ptr_q + PTR_W'(issue_count_i);
            if (fetch_en) begin
                pc_q     <= pc_q + word_t'(4 * FW);
                wr_ptr_q <= wr_ptr_q + PTR_W'(FW);
                occ_q    <= occ_q + occ_t'(FW) - occ_t'(issue_count_i);
            end else begin
                occ_q    <= occ_q - occ_t'(issue_count_i);
            end
        end
    end

    // Push three entries at the write pointer
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            for (int i = 0; i < FW; i++) begin
                buf_mem[wr_ptr_q + PTR_W'(i)] <= '{instr: instr_i[i], pc: inst_addr_o[i]};
            end
        end
    end

endmodule

//--- hdl/issue_decode.sv
`include "ss_core_cfg.svh"

module issue_decode
    import ss_core_pkg::*;
(
    input  fetch_entry_t [`SS_ISSUE_WIDTH-1:0] head_i,
    input  occ_t                               occupancy_i,
    output logic         [1:0]                 issue_count_o,
    output uop_t         [`SS_ISSUE_WIDTH-1:0] uops_o,
    output reg_idx_t     [`SS_ISSUE_WIDTH-1:0] rs1_o,
    output reg_idx_t     [`SS_ISSUE_WIDTH-1:0] rs2_o
);

    localparam int IW = `SS_ISSUE_WIDTH;

    // RV32I major opcodes that are kept
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ======================================================================
    // Per-slot decode
    // ======================================================================

    function automatic uop_t decode_slot(input word_t instr);
        uop_t       u;
        logic [6:0] opcode;
        logic [2:0] f3;
        logic       alt;
        opcode      = instr[6:0];
        f3          = instr[14:12];
        alt         = instr[30];
        u           = '0;
        u.alu_op    = ALU_NOP;
        u.rd        = instr[11:7];
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            // Shared funct3 map, bit 30 picks SUB/SRA
            case (f3)
                3'b000:  u.alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
                3'b001:  u.alu_op = ALU_SLL;
                3'b010:  u.alu_op = ALU_SLT;
                3'b011:  u.alu_op = ALU_SLTU;
                3'b100:  u.alu_op = ALU_XOR;
                3'b101:  u.alu_op = alt ? ALU_SRA : ALU_SRL;
                3'b110:  u.alu_op = ALU_OR;
                default: u.alu_op = ALU_AND;
            endcase
            u.use_imm = (opcode == OPC_OP_IMM);
            // Shifts take shamt, rest take the I-type immediate
            if (f3 == 3'b001 || f3 == 3'b101) begin
                u.imm = word_t'(instr[24:20]);
            end else begin
                u.imm = {{(`SS_XLEN-12){instr[31]}}, instr[31:20]};
            end
            u.writes_rd = (u.rd != '0);
        end else if (opcode == OPC_LUI) begin
            u.alu_op    = ALU_LUI;
            u.use_imm   = 1'b1;
            u.imm       = {instr[31:12], 12'b0};
            u.writes_rd = (u.rd != '0);
        end
        return u;
    endfunction

    uop_t dec     [IW];
    logic reads1  [IW];
    logic reads2  [IW];

    always_comb begin
        for (int i = 0; i < IW; i++) begin
            dec[i]    = decode_slot(head_i[i].instr);
            // Source use decides hazards, LUI reads nothing
            reads1[i] = (head_i[i].instr[6:0] == OPC_OP) ||
                        (head_i[i].instr[6:0] == OPC_OP_IMM);
            reads2[i] = (head_i[i].instr[6:0] == OPC_OP);
            rs1_o[i]  = head_i[i].instr[19:15];
            rs2_o[i]  = head_i[i].instr[24:20];
        end
    end

    // ======================================================================
    // Group formation, stops at first missing slot or RAW hazard
    // ======================================================================

    always_comb begin
        logic       stop;
        logic       dep;
        logic [1:0] count;
        stop  = 1'b0;
        count = '0;
        for (int j = 0; j < IW; j++) begin
            dep = 1'b0;
            // Earlier slots are all in the group at this point
            for (int i = 0; i < j; i++) begin
                if (dec[i].writes_rd &&
                    ((reads1[j] && rs1_o[j] == dec[i].rd) ||
                     (reads2[j] && rs2_o[j] == dec[i].rd))) begin
                    dep = 1'b1;
                end
            end
            if (!stop && (occ_t'(j) < occupancy_i) && !dep) begin
                count = count + 2'd1;
            end else begin
                stop = 1'b1;
            end
        end
        issue_count_o = count;
        for (int i = 0; i < IW; i++) begin
            uops_o[i]       = dec[i];
            uops_o[i].valid = (i < int'(count));
        end
    end

endmodule

//--- hdl/perf_counters.sv
`include "ss_core_cfg.svh"

module perf_counters
    import ss_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fetch_strobe_i,
    input  logic       stall_i,
    input  logic [1:0] executed_count_i,
    output perf_t      perf_o
);

    perf_t perf_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            perf_q <= '0;
        end else begin
            perf_q.cycles <= perf_q.cycles + 32'd1;
            // Whole group per push
            if (fetch_strobe_i) begin
                perf_q.fetched <= perf_q.fetched + 32'(`SS_ISSUE_WIDTH);
            end
            perf_q.executed <= perf_q.executed + 32'(executed_count_i);
            if (stall_i) begin
                perf_q.buffer_stalls <= perf_q.buffer_stalls + 32'd1;
            end
        end
    end

    assign perf_o = perf_q;

endmodule

//--- hdl/reg_file.sv
`include "ss_core_cfg.svh"

module reg_file
    import ss_core_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  reg_idx_t [`SS_ISSUE_WIDTH-1:0]      rs1_i,
    input  reg_idx_t [`SS_ISSUE_WIDTH-1:0]      rs2_i,
    output word_t    [`SS_ISSUE_WIDTH-1:0]      rs1_data_o,
    output word_t    [`SS_ISSUE_WIDTH-1:0]      rs2_data_o,
    input  retire_t  [`SS_ISSUE_WIDTH-1:0]      wr_i
);

    // x1..x31, x0 is not stored
    word_t regs_q [1:`SS_NUM_REGS-1];

    // Six asynchronous reads
    always_comb begin
        for (int i = 0; i < `SS_ISSUE_WIDTH; i++) begin
            rs1_data_o[i] = (rs1_i[i] == '0) ? '0 : regs_q[rs1_i[i]];
            rs2_data_o[i] = (rs2_i[i] == '0) ? '0 : regs_q[rs2_i[i]];
        end
    end

    // Lanes in order so the highest lane wins on equal rd
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 1; r < `SS_NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `SS_ISSUE_WIDTH; l++) begin
                if (wr_i[l].valid && wr_i[l].rd != '0) begin
                    regs_q[wr_i[l].rd] <= wr_i[l].data;
                end
            end
        end
    end

endmodule

//--- hdl/ss_core_cfg.svh
`ifndef SS_CORE_CFG_SVH
`define SS_CORE_CFG_SVH

// ==========================================================================
// Core sizing
// ==========================================================================

// Data word and address width
`define SS_XLEN 32

// Instructions fetched, issued, executed and retired per cycle
`define SS_ISSUE_WIDTH 3

// Instruction buffer entries, power of two
`define SS_BUF_DEPTH 16

// Architectural integer registers
`define SS_NUM_REGS 32

// First fetch address out of reset
`define SS_RESET_PC 0

`endif

//--- hdl/ss_core_pkg.sv
`include "ss_core_cfg.svh"

package ss_core_pkg;

    // Basic scalar types
    typedef logic [`SS_XLEN-1:0] word_t;
    typedef logic [$clog2(`SS_NUM_REGS)-1:0] reg_idx_t;
    // Occupancy 0..depth, one bit wider than a pointer
    typedef logic [$clog2(`SS_BUF_DEPTH):0] occ_t;

    // One buffered instruction with its address
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetch_entry_t;

    // Kept integer operations, NOP for everything else
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_NOP
    } alu_op_e;

    // Decoded issue slot
    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     writes_rd;  // Nonzero rd on a writing opcode
        logic     use_imm;
        word_t    imm;
    } uop_t;

    // Register write, also the retire record
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    // Performance counters
    typedef struct packed {
        logic [31:0] cycles;
        logic [31:0] fetched;
        logic [31:0] executed;
        logic [31:0] buffer_stalls;
    } perf_t;

endpackage

//--- hdl/ss_core_top.sv
`include "ss_core_cfg.svh"

module ss_core_top
    import ss_core_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    output word_t   [`SS_ISSUE_WIDTH-1:0]     inst_addr_o,
    input  word_t   [`SS_ISSUE_WIDTH-1:0]     instr_i,
    output retire_t [`SS_ISSUE_WIDTH-1:0]     retire_o,
    output perf_t                             perf_o,
    output occ_t                              occupancy_o
);

    // ======================================================================
    // Inter-unit wiring
    // ======================================================================

    fetch_entry_t [`SS_ISSUE_WIDTH-1:0] head;
    uop_t         [`SS_ISSUE_WIDTH-1:0] uops;
    reg_idx_t     [`SS_ISSUE_WIDTH-1:0] rs1;
    reg_idx_t     [`SS_ISSUE_WIDTH-1:0] rs2;
    word_t        [`SS_ISSUE_WIDTH-1:0] rs1_data;
    word_t        [`SS_ISSUE_WIDTH-1:0] rs2_data;
    retire_t      [`SS_ISSUE_WIDTH-1:0] wr;
    logic         [1:0]                 issue_count;
    logic         [1:0]                 executed_count;
    logic                               fetch_strobe;
    logic                               stall;

    // Fetch and instruction buffer
    fetch_buffer i_fetch_buffer (
        .clk            (clk),
        .reset          (reset),
        .inst_addr_o    (inst_addr_o),
        .instr_i        (instr_i),
        .issue_count_i  (issue_count),
        .head_o         (head),
        .occupancy_o    (occupancy_o),
        .fetch_strobe_o (fetch_strobe),
        .stall_o        (stall)
    );

    // Decode and group forming
    issue_decode i_issue_decode (
        .head_i        (head),
        .occupancy_i   (occupancy_o),
        .issue_count_o (issue_count),
        .uops_o        (uops),
        .rs1_o         (rs1),
        .rs2_o         (rs2)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (wr)
    );

    // ALU lanes, write back on the issue edge
    execute_stage i_execute_stage (
        .clk              (clk),
        .reset            (reset),
        .uops_i           (uops),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .wr_o             (wr),
        .retire_o         (retire_o),
        .executed_count_o (executed_count)
    );

    perf_counters i_perf_counters (
        .clk              (clk),
        .reset            (reset),
        .fetch_strobe_i   (fetch_strobe),
        .stall_i          (stall),
        .executed_count_i (executed_count),
        .perf_o           (perf_o)
    );

endmodule

//--- sources.f
+incdir+hdl
+incdir+dv
hdl/ss_core_pkg.sv
hdl/fetch_buffer.sv
hdl/issue_decode.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/perf_counters.sv
hdl/ss_core_top.sv
dv/ss_core_tb.sv
